/* hw/elevator_pkg.sv */
// Elevator floor request package
// Floor and car state encodings shared by the request controller
`default_nettype none

package elevator_pkg;

    ////////////////////
    // Floor encoding
    localparam int FLOOR_COUNT = 11;

    // Floor 0 is the first floor
    typedef logic [3:0] floor_t;

    // One bit per floor for buttons and lights
    typedef logic [FLOOR_COUNT-1:0] floor_mask_t;

    // Queue occupancy, 0 to FLOOR_COUNT
    typedef logic [3:0] count_t;

    ////////////////////
    // Car state codes from the motion FSM
    typedef logic [5:0] state_code_t;

    // Codes 0 to 10 are stopped at that floor, 11 to 30 are moving
    localparam state_code_t STOP_LAST_CODE = 6'd10;
    localparam state_code_t EMERGENCY_CODE = 6'd31;

    // Dispatch FSM states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        DEPART = 2'd1,
        TRAVEL = 2'd2
    } dispatch_state_t;

    // True for any stopped-at-floor code
    function automatic logic is_stop_state(state_code_t code);
        return code <= STOP_LAST_CODE;
    endfunction

endpackage

`default_nettype wire

/* hw/request_register.sv */
// Request register, holds hall and car panel lights
// and selects at most one new floor per cycle for the queue
`default_nettype none

module request_register (
    input  wire                            clock,
    input  wire                            reset_n,
    input  wire                            flush,
    input  wire elevator_pkg::floor_mask_t floor_call_buttons,
    input  wire elevator_pkg::floor_mask_t panel_buttons,
    input  wire elevator_pkg::floor_t      current_floor,
    input  wire                            served,
    output elevator_pkg::floor_mask_t      call_button_lights,
    output elevator_pkg::floor_mask_t      panel_button_lights,
    output logic                           push,
    output elevator_pkg::floor_t           push_floor
);
    import elevator_pkg::*;

    floor_mask_t current_mask;
    floor_mask_t new_mask;
    floor_mask_t accept_mask;
    floor_mask_t clear_mask;
    floor_t      pick_floor;
    logic        pick_valid;

    assign current_mask = floor_mask_t'(1) << current_floor;

    // Pressed, not yet lit, not where the car stands
    assign new_mask = (floor_call_buttons | panel_buttons)
                    & ~(call_button_lights | panel_button_lights)
                    & ~current_mask
                    & {FLOOR_COUNT{~flush}};

    ////////////////////
    // Lowest new floor wins
    always_comb begin
        pick_floor = '0;
        pick_valid = 1'b0;
        for (int i = FLOOR_COUNT - 1; i >= 0; i--) begin
            if (new_mask[i]) begin
                pick_floor = floor_t'(i);
                pick_valid = 1'b1;
            end
        end
    end

    assign accept_mask = pick_valid ? (floor_mask_t'(1) << pick_floor) : '0;
    assign clear_mask  = served ? current_mask : '0;

    ////////////////////
    // Light registers
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else if (flush) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else begin
            // Only the lights whose button is pressed get set
            call_button_lights  <= (call_button_lights | (accept_mask & floor_call_buttons))
                                 & ~clear_mask;
            panel_button_lights <= (panel_button_lights | (accept_mask & panel_buttons))
                                 & ~clear_mask;
        end
    end

    // One push per accepted floor
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            push <= 1'b0;
        end else begin
            push <= pick_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (pick_valid) begin
            push_floor <= pick_floor;
        end
    end

endmodule

`default_nettype wire

/* hw/floor_queue.sv */
// Floor queue, eleven-entry FIFO of requested floors
// kept in order of arrival with an occupancy count
`default_nettype none

module floor_queue (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire                       flush,
    input  wire                       push,
    input  wire elevator_pkg::floor_t push_floor,
    input  wire                       served,
    output elevator_pkg::floor_t      head_floor,
    output logic                      empty
);
    import elevator_pkg::*;

    floor_t slots [FLOOR_COUNT];
    count_t wr_ptr;
    count_t rd_ptr;
    count_t count;
    logic   pop;

    // Step a slot index with wrap at the last slot
    function automatic count_t next_ptr(count_t ptr);
        return (ptr == count_t'(FLOOR_COUNT - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty      = (count == '0);
    assign head_floor = slots[rd_ptr];
    assign pop        = served && !empty;

    ////////////////////
    // Pointers and count
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // A floor is queued at most once, so push never finds it full
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Slot storage
    always_ff @(posedge clock) begin
        if (push) begin
            slots[wr_ptr] <= push_floor;
        end
    end

endmodule

`default_nettype wire

/* hw/dispatch_fsm.sv */
// Dispatch FSM, offers the oldest queued floor to the motion FSM,
// retires it on arrival and gates the door requests
`default_nettype none

module dispatch_fsm (
    input  wire                            clock,
    input  wire                            reset_n,
    input  wire                            power_switch,
    input  wire                            emergency_btn,
    input  wire                            door_open_btn,
    input  wire                            door_close_btn,
    input  wire elevator_pkg::state_code_t elevator_state,
    input  wire elevator_pkg::floor_t      current_floor,
    input  wire elevator_pkg::floor_t      head_floor,
    input  wire                            empty,
    output logic                           flush,
    output logic                           served,
    output elevator_pkg::floor_t           target_floor,
    output logic                           direction_up,
    output logic                           activate_elevator,
    output logic                           door_open_allowed,
    output logic                           door_close_allowed
);
    import elevator_pkg::*;

    dispatch_state_t state;
    logic            stopped;
    logic            at_target;

    // Power loss or emergency drops every request
    assign flush     = !power_switch || emergency_btn;
    assign stopped   = is_stop_state(elevator_state);
    assign at_target = stopped && (current_floor == target_floor);

    ////////////////////
    // State register
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= IDLE;
            served       <= 1'b0;
            target_floor <= '0;
            direction_up <= 1'b0;
        end else if (flush) begin
            state  <= IDLE;
            served <= 1'b0;
        end else begin
            served <= 1'b0;
            case (state)
                IDLE: begin
                    // Wait out a pending pop before reading the head again
                    if (stopped && !empty && !served) begin
                        if (head_floor == current_floor) begin
                            served <= 1'b1;
                        end else begin
                            target_floor <= head_floor;
                            direction_up <= (head_floor > current_floor);
                            state        <= DEPART;
                        end
                    end
                end
                DEPART: begin
                    if (!stopped) begin
                        state <= TRAVEL;
                    end
                end
                TRAVEL: begin
                    if (at_target) begin
                        served <= 1'b1;
                        state  <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Activation drops as soon as flush rises, not one edge later
    assign activate_elevator = (state == DEPART) && !flush;

    ////////////////////
    // Door gating
    assign door_open_allowed  = door_open_btn && stopped && power_switch;
    assign door_close_allowed = door_close_btn && stopped && power_switch;

endmodule

`default_nettype wire

/* hw/floor_logic_top.sv */
// Floor request controller top, request register and queue
// steered by the dispatch FSM
`default_nettype none

module floor_logic_top (
    input  wire                            clock,
    input  wire                            reset_n,
    input  wire elevator_pkg::floor_mask_t floor_call_buttons,
    input  wire elevator_pkg::floor_mask_t panel_buttons,
    input  wire                            door_open_btn,
    input  wire                            door_close_btn,
    input  wire                            emergency_btn,
    input  wire                            power_switch,
    input  wire elevator_pkg::state_code_t elevator_state,
    input  wire elevator_pkg::floor_t      current_floor,
    output elevator_pkg::floor_t           target_floor,
    output logic                           direction_up,
    output logic                           activate_elevator,
    output elevator_pkg::floor_mask_t      call_button_lights,
    output elevator_pkg::floor_mask_t      panel_button_lights,
    output logic                           door_open_allowed,
    output logic                           door_close_allowed
);
    import elevator_pkg::*;

    logic   flush;
    logic   served;
    logic   push;
    floor_t push_floor;
    floor_t head_floor;
    logic   empty;

    ////////////////////
    // Button capture
    request_register u_request_register (
        .clock               (clock),
        .reset_n             (reset_n),
        .flush               (flush),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .current_floor       (current_floor),
        .served              (served),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .push                (push),
        .push_floor          (push_floor)
    );

    // Requested floors in arrival order
    floor_queue u_floor_queue (
        .clock      (clock),
        .reset_n    (reset_n),
        .flush      (flush),
        .push       (push),
        .push_floor (push_floor),
        .served     (served),
        .head_floor (head_floor),
        .empty      (empty)
    );

    ////////////////////
    // Dispatch and doors
    dispatch_fsm u_dispatch_fsm (
        .clock              (clock),
        .reset_n            (reset_n),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .elevator_state     (elevator_state),
        .current_floor      (current_floor),
        .head_floor         (head_floor),
        .empty              (empty),
        .flush              (flush),
        .served             (served),
        .target_floor       (target_floor),
        .direction_up       (direction_up),
        .activate_elevator  (activate_elevator),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

`default_nettype wire

/* bench/floor_logic_checker.sv */
// Floor request controller checker
// Concurrent rules on flush, door gating and light clearing
`default_nettype none

module floor_logic_checker (
    input wire                            clock,
    input wire                            reset_n,
    input wire                            power_switch,
    input wire                            emergency_btn,
    input wire                            activate_elevator,
    input wire                            door_open_allowed,
    input wire                            door_close_allowed,
    input wire elevator_pkg::state_code_t elevator_state,
    input wire elevator_pkg::floor_mask_t call_button_lights,
    input wire elevator_pkg::floor_mask_t panel_button_lights
);
    timeunit 1ns;
    timeprecision 100ps;
    import elevator_pkg::*;

    int fail_count = 0;

    // No dispatch without power or during an emergency
    no_activate_on_flush: assert property (
        @(posedge clock) disable iff (!reset_n)
        (!power_switch || emergency_btn) |-> !activate_elevator
    ) else begin
        $error("activate_elevator high while power is off or emergency is pressed");
        fail_count++;
    end

    ////////////////////
    // Doors only at a floor
    doors_only_stopped: assert property (
        @(posedge clock) disable iff (!reset_n)
        (door_open_allowed || door_close_allowed) |-> is_stop_state(elevator_state)
    ) else begin
        $error("Door output high while the car is not stopped");
        fail_count++;
    end

    // Emergency wipes every light by the next cycle
    emergency_clears_lights: assert property (
        @(posedge clock) disable iff (!reset_n)
        emergency_btn |=> (call_button_lights == '0 && panel_button_lights == '0)
    ) else begin
        $error("Lights still on the cycle after emergency");
        fail_count++;
    end

endmodule

`default_nettype wire

/* bench/floor_logic_tb.sv */
// Floor request controller testbench
// Table of presses with expected lights, targets and doors, plus a car model
`default_nettype none

module floor_logic_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import elevator_pkg::*;

    typedef enum logic [1:0] {PRESS, SERVE, HOLD_OFF} mode_t;

    // levels is {power, emergency, door_open, door_close}, exp_doors is {open, close}
    typedef struct packed {
        mode_t       mode;
        logic [2:0]  hold;
        floor_mask_t call;
        floor_mask_t panel;
        logic [3:0]  levels;
        floor_mask_t exp_call;
        floor_mask_t exp_panel;
        floor_t      exp_target;
        logic        exp_up;
        logic [1:0]  exp_doors;
    } row_t;

    logic        clock = 1'b0;
    logic        reset_n = 1'b0;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    state_code_t elevator_state;
    floor_t      current_floor;
    floor_t      target_floor;
    logic        direction_up;
    logic        activate_elevator;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    logic        door_open_allowed;
    logic        door_close_allowed;

    row_t rows[$];
    int   error_count = 0;
    int   cycle_count = 0;
    int   cycle_limit = 0;

    floor_logic_top dut (.*);

    bind floor_logic_top floor_logic_checker u_checker (
        .clock               (clock),
        .reset_n             (reset_n),
        .power_switch        (power_switch),
        .emergency_btn       (emergency_btn),
        .activate_elevator   (activate_elevator),
        .door_open_allowed   (door_open_allowed),
        .door_close_allowed  (door_close_allowed),
        .elevator_state      (elevator_state),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    always #2 clock = ~clock;

    // Run limit, 40 cycles per table row
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Run timed out after %0d cycles", cycle_count);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_equal(input int actual, input int expected, input string what,
                               input int idx);
        assert (actual == expected)
        else begin
            $display("Mismatch at %0d ns: test %0d %s is 0x%0h, expected 0x%0h",
                     $time, idx, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic add_row(input mode_t mode, input int hold, input floor_mask_t call,
                           input floor_mask_t panel, input logic [3:0] levels,
                           input floor_mask_t exp_call, input floor_mask_t exp_panel,
                           input int exp_target, input logic exp_up,
                           input logic [1:0] exp_doors);
        row_t r;
        r.mode       = mode;
        r.hold       = 3'(hold);
        r.call       = call;
        r.panel      = panel;
        r.levels     = levels;
        r.exp_call   = exp_call;
        r.exp_panel  = exp_panel;
        r.exp_target = floor_t'(exp_target);
        r.exp_up     = exp_up;
        r.exp_doors  = exp_doors;
        rows.push_back(r);
    endtask

    ////////////////////
    // Stimulus table, car starts stopped at floor 2
    task automatic build_table();
        add_row(PRESS,    1, 11'h000, 11'h080, 4'b1000, 11'h000, 11'h080, 0, 1'b0, 2'b00);
        add_row(SERVE,    1, 11'h000, 11'h000, 4'b1000, 11'h000, 11'h000, 7, 1'b1, 2'b00);
        // Press at the floor where the car stands
        add_row(HOLD_OFF, 1, 11'h080, 11'h080, 4'b1000, 11'h000, 11'h000, 0, 1'b0, 2'b00);
        // Arrival order 9, 4, 6
        add_row(PRESS,    1, 11'h200, 11'h000, 4'b1000, 11'h200, 11'h000, 0, 1'b0, 2'b00);
        add_row(PRESS,    1, 11'h010, 11'h000, 4'b1000, 11'h210, 11'h000, 0, 1'b0, 2'b00);
        add_row(PRESS,    1, 11'h040, 11'h000, 4'b1000, 11'h250, 11'h000, 0, 1'b0, 2'b00);
        add_row(SERVE,    1, 11'h000, 11'h000, 4'b1000, 11'h050, 11'h000, 9, 1'b1, 2'b00);
        add_row(SERVE,    1, 11'h000, 11'h000, 4'b1000, 11'h040, 11'h000, 4, 1'b0, 2'b00);
        add_row(SERVE,    1, 11'h000, 11'h000, 4'b1000, 11'h000, 11'h000, 6, 1'b1, 2'b00);
        // Held press of 1, 3, 8 and 10 is taken lowest first
        add_row(PRESS,    4, 11'h400, 11'h10A, 4'b1000, 11'h400, 11'h10A, 0, 1'b0, 2'b00);
        add_row(SERVE,    1, 11'h000, 11'h000, 4'b1000, 11'h400, 11'h108, 1, 1'b0, 2'b00);
        add_row(SERVE,    1, 11'h000, 11'h000, 4'b1000, 11'h400, 11'h100, 3, 1'b1, 2'b00);
        add_row(SERVE,    1, 11'h000, 11'h000, 4'b1000, 11'h400, 11'h000, 8, 1'b1, 2'b00);
        add_row(SERVE,    1, 11'h000, 11'h000, 4'b1000, 11'h000, 11'h000, 10, 1'b1, 2'b00);
        // Emergency, then power-off, drop pending floors
        add_row(PRESS,    2, 11'h004, 11'h020, 4'b1000, 11'h004, 11'h020, 0, 1'b0, 2'b00);
        add_row(HOLD_OFF, 1, 11'h000, 11'h000, 4'b1100, 11'h000, 11'h000, 0, 1'b0, 2'b00);
        add_row(HOLD_OFF, 1, 11'h000, 11'h000, 4'b1000, 11'h000, 11'h000, 0, 1'b0, 2'b00);
        add_row(PRESS,    1, 11'h000, 11'h008, 4'b1000, 11'h000, 11'h008, 0, 1'b0, 2'b00);
        add_row(HOLD_OFF, 1, 11'h000, 11'h000, 4'b0010, 11'h000, 11'h000, 0, 1'b0, 2'b00);
        add_row(HOLD_OFF, 1, 11'h000, 11'h000, 4'b1000, 11'h000, 11'h000, 0, 1'b0, 2'b00);
        // Door buttons, stopped and then moving
        add_row(PRESS,    1, 11'h000, 11'h000, 4'b1010, 11'h000, 11'h000, 0, 1'b0, 2'b10);
        add_row(PRESS,    1, 11'h000, 11'h000, 4'b1001, 11'h000, 11'h000, 0, 1'b0, 2'b01);
        add_row(PRESS,    1, 11'h001, 11'h000, 4'b1010, 11'h001, 11'h000, 0, 1'b0, 2'b10);
        add_row(SERVE,    1, 11'h000, 11'h000, 4'b1010, 11'h000, 11'h000, 0, 1'b0, 2'b10);
    endtask

    ////////////////////
    // One row, presses then car model or quiet window
    task automatic run_row(input row_t r, input int idx);
        int move_cycles;
        @(posedge clock);
        #1;
        floor_call_buttons = r.call;
        panel_buttons      = r.panel;
        {power_switch, emergency_btn, door_open_btn, door_close_btn} = r.levels;
        repeat (r.hold) @(posedge clock);
        #1;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        case (r.mode)
            SERVE: begin
                @(negedge clock);
                while (!activate_elevator) @(negedge clock);
                check_equal(int'(target_floor), int'(r.exp_target), "target floor", idx);
                check_equal(int'(direction_up), int'(r.exp_up), "direction", idx);
                // Car leaves the stop codes for 2 to 6 cycles
                @(posedge clock);
                #1;
                elevator_state = r.exp_up ? 6'd15 : 6'd25;
                move_cycles = 2 + int'($urandom % 5);
                repeat (move_cycles) begin
                    @(negedge clock);
                    check_equal(int'({door_open_allowed, door_close_allowed}), 0,
                                "door outputs while moving", idx);
                end
                @(posedge clock);
                #1;
                elevator_state = state_code_t'(r.exp_target);
                current_floor  = r.exp_target;
                repeat (3) @(posedge clock);
            end
            HOLD_OFF: begin
                repeat (6) begin
                    @(negedge clock);
                    check_equal(int'(activate_elevator), 0, "activate_elevator", idx);
                end
            end
            default: begin
            end
        endcase
        @(negedge clock);
        check_equal(int'(call_button_lights), int'(r.exp_call), "call lights", idx);
        check_equal(int'(panel_button_lights), int'(r.exp_panel), "panel lights", idx);
        check_equal(int'({door_open_allowed, door_close_allowed}), int'(r.exp_doors),
                    "door outputs", idx);
    endtask

    initial begin
        int failed_tests;
        int errs_before;
        failed_tests       = 0;
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        elevator_state     = 6'd2;
        current_floor      = 4'd2;
        void'($urandom(32'hd2f7_3562));
        build_table();
        cycle_limit = rows.size() * 40;

        repeat (5) @(posedge clock);
        #1;
        reset_n = 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            errs_before = error_count;
            run_row(rows[i], i);
            if (error_count != errs_before) begin
                failed_tests++;
            end
            $display("Test %0d %s: %s", i, rows[i].mode.name(),
                     (error_count == errs_before) ? "PASS" : "FAIL");
        end

        $display("Tests run %0d, failed %0d, check errors %0d, assertion errors %0d",
                 rows.size(), failed_tests, error_count, dut.u_checker.fail_count);
        if (error_count == 0 && dut.u_checker.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hw/elevator_pkg.sv
hw/request_register.sv
hw/floor_queue.sv
hw/dispatch_fsm.sv
hw/floor_logic_top.sv
bench/floor_logic_checker.sv
bench/floor_logic_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the floor request controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/100ps \
    -f sources.f --top-module floor_logic_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vfloor_logic_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "All tests passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
